/* bench/lightBoardPatterns.txt */
// Columns (hex): operation, argument A, argument B
// 1 edit channel A to level B, 2 record cue A, 3 recall cue A, 4 mode 00,
// 5 check A frames, 6 expect cueValid A, 0 end of script
5 001 000
6 000 000
1 001 0a5
1 003 03c
1 008 0ff
1 000 077
1 009 055
5 001 000
2 002 000
6 004 000
2 006 000
6 004 000
1 001 001
1 005 080
5 001 000
3 002 000
5 001 000
3 004 000
5 001 000
1 002 05a
4 000 000
6 004 000
5 003 000
0 000 000

/* bench/lightBoardTb.sv */
`timescale 1ns/1ps

module lightBoardTb import lightBoardPkg::*; ();

	localparam int NumChannels = 8;
	localparam int NumCues = 5;
	localparam int BitCycles = 2;
	localparam int BreakBits = 22;
	localparam int MabBits = 2;
	localparam int FrameBits = BreakBits + MabBits + SlotBits * (NumChannels + 1);
	localparam int FrameCycles = FrameBits * BitCycles;
	localparam int StepCycles = 6; // Enter held 3, released 3
	localparam int OpCycles = 3 * StepCycles;
	localparam int MaxOps = 64;

	logic clk;
	logic rst;
	panelWord_t panel;
	logic enter;
	logic send;
	logic dmxOut;
	logic busy;
	logic [NumCues-1:0] cueValid;
	panelState_t panelState;

	logic [15:0] patMem [0:3*MaxOps-1];
	int modelLive [0:NumChannels];
	int modelCue [0:NumCues-1][0:NumChannels];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int timeoutLimit = 100000;
	int busyCycles;
	logic sendHold;

	lightBoard #(
		.NumChannels(NumChannels),
		.NumCues(NumCues),
		.BitCycles(BitCycles),
		.BreakBits(BreakBits),
		.MabBits(MabBits)
	) dut (
		.clk(clk),
		.rst(rst),
		.panel(panel),
		.enter(enter),
		.send(send),
		.dmxOut(dmxOut),
		.busy(busy),
		.cueValid(cueValid),
		.panelState(panelState)
	);

	always
	begin
		#10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > timeoutLimit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string name, input int got, input int expected);
		checkCount++;
		assert (got == expected)
		else
		begin
			errorCount++;
			$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, got);
		end
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic menuStep(input int value);
		panel = panelWord_t'(value[PanelBits-1:0]);
		enter = 1'b1;
		waitCycles(3);
		enter = 1'b0;
		waitCycles(3);
	endtask

	task automatic editLevel(input int channel, input int level);
		menuStep(3);
		menuStep(channel);
		menuStep(level);
		if (channel != 0 && channel <= NumChannels)
			modelLive[channel] = level;
	endtask

	task automatic cueCommand(input int mode, input int cue, input bit record);
		menuStep(mode);
		menuStep(cue);
		if (cue < NumCues)
		begin
			for (int ch = 1; ch <= NumChannels; ch++)
			begin
				if (record)
					modelCue[cue][ch] = modelLive[ch];
				else
					modelLive[ch] = modelCue[cue][ch];
			end
		end
	endtask

	// Bit b counts from the first mark-after-break bit
	function automatic logic expectedBit(input int b);
		int slot;
		int pos;
		int level;
		if (b < MabBits)
			return 1'b1;
		slot = (b - MabBits) / SlotBits;
		pos = (b - MabBits) % SlotBits;
		level = (slot == 0) ? 0 : modelLive[slot];
		if (pos == 0)
			return 1'b0;
		if (pos <= LevelBits)
			return level[pos-1];
		return 1'b1;
	endfunction

	task automatic nextSample;
		@(posedge clk);
		#2 send = sendHold;
		@(negedge clk);
		if (busy)
			busyCycles++;
	endtask

	task automatic checkFrames(input int n);
		int gap;
		int lowCount;
		sendHold = 1'b1;
		send = 1'b1;
		@(negedge clk);
		for (int k = 0; k < n; k++)
		begin
			busyCycles = 0;
			gap = 0;
			while (dmxOut)
			begin
				gap++;
				nextSample();
			end
			checkValue("idle gap", gap, 1);
			if (k == n - 1)
				sendHold = 1'b0; // Let the last frame end the burst
			lowCount = 0;
			while (!dmxOut)
			begin
				lowCount++;
				nextSample();
			end
			checkValue("break length", lowCount, BreakBits * BitCycles);
			for (int b = 0; b < FrameBits - BreakBits; b++)
			begin
				repeat (BitCycles / 2) nextSample();
				checkValue("dmxOut", dmxOut, expectedBit(b));
				repeat (BitCycles - BitCycles / 2) nextSample();
			end
			checkValue("busy cycles", busyCycles, FrameCycles);
			checkValue("busy", busy, 0);
		end
		@(posedge clk);
		#2;
	endtask

	initial
	begin
		int numOps;
		int numFrames;
		int op;
		clk = 1'b0;
		rst = 1'b0;
		panel = '0;
		enter = 1'b0;
		send = 1'b0;
		sendHold = 1'b0;
		for (int i = 0; i < 3 * MaxOps; i++)
			patMem[i] = '0;
		$readmemh("bench/lightBoardPatterns.txt", patMem);
		for (int ch = 0; ch <= NumChannels; ch++)
		begin
			modelLive[ch] = 0;
			for (int c = 0; c < NumCues; c++)
				modelCue[c][ch] = 0;
		end

		numOps = 0;
		numFrames = 0;
		while (numOps < MaxOps && patMem[3*numOps] != 0)
		begin
			if (patMem[3*numOps] == 5)
				numFrames += patMem[3*numOps+1];
			numOps++;
		end
		timeoutLimit = 20 + numOps * OpCycles + numFrames * (FrameCycles + 4) + 200;

		repeat (10) @(posedge clk);
		#2 rst = 1'b1;
		waitCycles(1);
		checkValue("dmxOut", dmxOut, 1);
		checkValue("busy", busy, 0);
		checkValue("cueValid", cueValid, 0);

		for (int i = 0; i < numOps; i++)
		begin
			op = patMem[3*i];
			case (op)
				1: editLevel(patMem[3*i+1], patMem[3*i+2]);
				2: cueCommand(2, patMem[3*i+1], 1'b1);
				3: cueCommand(1, patMem[3*i+1], 1'b0);
				4: menuStep(0);
				5: checkFrames(patMem[3*i+1]);
				6: checkValue("cueValid", cueValid, patMem[3*i+1]);
				default:
				begin
					errorCount++;
					$display("Pattern line %0d holds an unknown operation %0d", i, op);
				end
			endcase
			if (op >= 1 && op <= 4)
				checkValue("panelState", panelState, Home); // Menu back home after the step
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* bench/lightBoard_assert.sv */
`timescale 1ns/1ps

module lightBoardAssert import lightBoardPkg::*;
#(
	parameter int NumCues = 5
)
(
	input logic clk,
	input logic rst,
	input logic busy,
	input logic dmxOut,
	input logic [NumCues-1:0] cueValid,
	input editCmd_t cmd
);

	// Line idles at mark outside a frame
	idleHigh: assert property (@(posedge clk) disable iff (!rst) !busy |-> dmxOut)
		else $error("dmxOut is low while the transmitter is idle");

	cueValidSticky: assert property (@(posedge clk) disable iff (!rst)
		(($past(cueValid) & ~cueValid) == '0))
		else $error("a cueValid bit fell");

	oneStrobe: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({cmd.writeLevel, cmd.recordCue, cmd.recallCue}))
		else $error("more than one command strobe is high");

endmodule

bind lightBoard lightBoardAssert #(.NumCues(NumCues)) protocolChecks (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.dmxOut(dmxOut),
	.cueValid(cueValid),
	.cmd(cmd)
);

/* flist.f */
hdl/lightBoardPkg.sv
hdl/panelSequencer.sv
hdl/sceneStore.sv
hdl/dmxTransmitter.sv
hdl/lightBoard.sv
bench/lightBoard_assert.sv
bench/lightBoardTb.sv

/* hdl/dmxTransmitter.sv */
`timescale 1ns/1ps

module dmxTransmitter import lightBoardPkg::*;
#(
	parameter int NumChannels = 512,
	parameter int BitCycles = 200,
	parameter int BreakBits = 22,
	parameter int MabBits = 2
)
(
	input logic clk,
	input logic rst,
	input logic send,
	input logic [LevelBits-1:0] slotLevel,
	output logic [ChannelBits-1:0] slotIndex,
	output logic dmxOut,
	output logic busy
);

	localparam int TimerBits = $clog2(BitCycles + 1);
	localparam int CountBits = $clog2(BreakBits + MabBits + SlotBits);
	localparam int SlotCntBits = $clog2(NumChannels + 2);

	framePhase_t phase;
	logic [TimerBits-1:0] bitTimer;
	logic [CountBits-1:0] bitCount;
	logic [SlotCntBits-1:0] slotCount;
	logic [SlotBits-1:0] shiftReg;
	logic periodEnd;

	assign periodEnd = (bitTimer == BitCycles - 1);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			phase <= PhaseIdle;
			bitTimer <= '0;
			bitCount <= '0;
			slotCount <= '0;
			shiftReg <= '1;
			busy <= 1'b0;
		end
		else if (phase == PhaseIdle)
		begin
			if (send)
			begin
				phase <= PhaseBreak;
				busy <= 1'b1;
				bitTimer <= '0;
				bitCount <= '0;
			end
		end
		else if (!periodEnd)
			bitTimer <= bitTimer + 1'b1;
		else
		begin
			bitTimer <= '0;
			bitCount <= bitCount + 1'b1;
			case (phase)
				PhaseBreak:
					if (bitCount == BreakBits - 1)
					begin
						phase <= PhaseMab;
						bitCount <= '0;
					end
				PhaseMab:
					if (bitCount == MabBits - 1)
					begin
						phase <= PhaseSlot;
						bitCount <= '0;
						slotCount <= '0;
						shiftReg <= {{(SlotBits-1){1'b1}}, 1'b0};
					end
				default:
					if (bitCount == '0)
						shiftReg <= {{(SlotBits-LevelBits){1'b1}}, slotLevel}; // Level taken during start bit
					else if (bitCount == SlotBits - 1)
					begin
						bitCount <= '0;
						if (slotCount == NumChannels)
						begin
							phase <= PhaseIdle;
							busy <= 1'b0;
						end
						else
						begin
							slotCount <= slotCount + 1'b1;
							shiftReg <= {{(SlotBits-1){1'b1}}, 1'b0};
						end
					end
					else
						shiftReg <= {1'b1, shiftReg[SlotBits-1:1]}; // LSB first, stop bits fill in
			endcase
		end
	end

	assign slotIndex = ChannelBits'(slotCount);

	// Line idles high between frames
	assign dmxOut = (phase == PhaseBreak) ? 1'b0 :
		(phase == PhaseSlot) ? shiftReg[0] : 1'b1;

endmodule

/* hdl/lightBoard.sv */
`timescale 1ns/1ps

module lightBoard import lightBoardPkg::*;
#(
	parameter int NumChannels = 512,
	parameter int NumCues = 5,
	parameter int BitCycles = 200, // 4 us per bit at 50 MHz
	parameter int BreakBits = 22,
	parameter int MabBits = 2
)
(
	input logic clk,
	input logic rst,
	input panelWord_t panel,
	input logic enter,
	input logic send,
	output logic dmxOut,
	output logic busy,
	output logic [NumCues-1:0] cueValid,
	output panelState_t panelState
);

	editCmd_t cmd;
	logic [ChannelBits-1:0] slotIndex;
	logic [LevelBits-1:0] slotLevel;

	panelSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.panel(panel),
		.enter(enter),
		.cmd(cmd),
		.panelState(panelState)
	);

	sceneStore #(.NumChannels(NumChannels), .NumCues(NumCues)) store (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.slotIndex(slotIndex),
		.slotLevel(slotLevel),
		.cueValid(cueValid)
	);

	dmxTransmitter #(
		.NumChannels(NumChannels),
		.BitCycles(BitCycles),
		.BreakBits(BreakBits),
		.MabBits(MabBits)
	) transmitter (
		.clk(clk),
		.rst(rst),
		.send(send),
		.slotLevel(slotLevel),
		.slotIndex(slotIndex),
		.dmxOut(dmxOut),
		.busy(busy)
	);

endmodule

/* hdl/lightBoardPkg.sv */
package lightBoardPkg;

	localparam int PanelBits = 10;
	localparam int LevelBits = 8;
	localparam int ChannelBits = 9; // Channel 0 is the start code
	localparam int CueBits = 3;
	localparam int SlotBits = 11; // Start bit, level, two stop bits

	// One switch word, read three ways depending on the menu step
	typedef union packed {
		struct packed {
			logic [PanelBits-3:0] unused;
			logic [1:0] mode;
		} modeView;
		struct packed {
			logic [PanelBits-ChannelBits-1:0] unused;
			logic [ChannelBits-LevelBits-1:0] chanHigh; // Channel is {chanHigh, level}
			logic [LevelBits-1:0] level;
		} chanLevel;
		struct packed {
			logic [PanelBits-CueBits-1:0] unused;
			logic [CueBits-1:0] cue;
		} cueView;
	} panelWord_t;

	typedef enum logic [4:0] {
		Home, ChanRelease, ChanPress, LevelRelease, LevelPress, WriteRelease, WriteStrobe,
		RecCueRelease, RecCuePress, RecRelease, RecStrobe,
		CallCueRelease, CallCuePress, CallRelease, CallStrobe,
		NoneRelease
	} panelState_t;

	typedef enum logic [1:0] {PhaseIdle, PhaseBreak, PhaseMab, PhaseSlot} framePhase_t;

	typedef struct packed {
		logic writeLevel;
		logic recordCue;
		logic recallCue;
		logic [ChannelBits-1:0] channel;
		logic [LevelBits-1:0] level;
		logic [CueBits-1:0] cue;
	} editCmd_t;

endpackage

/* hdl/panelSequencer.sv */
`timescale 1ns/1ps

module panelSequencer import lightBoardPkg::*;
(
	input logic clk,
	input logic rst,
	input panelWord_t panel,
	input logic enter,
	output editCmd_t cmd,
	output panelState_t panelState
);

	panelState_t state;
	panelState_t nextState;
	logic [ChannelBits-1:0] channel;
	logic [LevelBits-1:0] level;
	logic [CueBits-1:0] cue;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= Home;
		else
			state <= nextState;
	end

	// Press moves on from a waiting state, release from a pressed one
	always_comb
	begin
		nextState = state;
		unique case (state)
			Home:
				if (enter)
				begin
					unique case (panel.modeView.mode)
						2'b11: nextState = ChanRelease;
						2'b10: nextState = RecCueRelease;
						2'b01: nextState = CallCueRelease;
						2'b00: nextState = NoneRelease;
					endcase
				end
			ChanRelease:
				if (!enter)
					nextState = ChanPress;
			ChanPress:
				if (enter)
					nextState = LevelRelease;
			LevelRelease:
				if (!enter)
					nextState = LevelPress;
			LevelPress:
				if (enter)
					nextState = WriteRelease;
			WriteRelease:
				if (!enter)
					nextState = WriteStrobe;
			RecCueRelease:
				if (!enter)
					nextState = RecCuePress;
			RecCuePress:
				if (enter)
					nextState = RecRelease;
			RecRelease:
				if (!enter)
					nextState = RecStrobe;
			CallCueRelease:
				if (!enter)
					nextState = CallCuePress;
			CallCuePress:
				if (enter)
					nextState = CallRelease;
			CallRelease:
				if (!enter)
					nextState = CallStrobe;
			NoneRelease:
				if (!enter)
					nextState = Home;
			WriteStrobe, RecStrobe, CallStrobe:
				nextState = Home; // Single cycle command
			default:
				nextState = Home;
		endcase
	end

	// Switch fields follow the panel until the operator moves on
	always_ff @(posedge clk)
	begin
		case (state)
			ChanRelease, ChanPress:
				channel <= {panel.chanLevel.chanHigh, panel.chanLevel.level};
			LevelRelease, LevelPress:
				level <= panel.chanLevel.level;
			RecCueRelease, RecCuePress, CallCueRelease, CallCuePress:
				cue <= panel.cueView.cue;
			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		cmd.writeLevel = (state == WriteStrobe);
		cmd.recordCue = (state == RecStrobe);
		cmd.recallCue = (state == CallStrobe);
		cmd.channel = channel;
		cmd.level = level;
		cmd.cue = cue;
	end

	assign panelState = state;

endmodule

/* hdl/sceneStore.sv */
`timescale 1ns/1ps

module sceneStore import lightBoardPkg::*;
#(
	parameter int NumChannels = 512,
	parameter int NumCues = 5
)
(
	input logic clk,
	input logic rst,
	input editCmd_t cmd,
	input logic [ChannelBits-1:0] slotIndex,
	output logic [LevelBits-1:0] slotLevel,
	output logic [NumCues-1:0] cueValid
);

	logic [LevelBits-1:0] live [1:NumChannels];
	logic [LevelBits-1:0] cueMem [NumCues][1:NumChannels];
	logic channelOk;
	logic cueOk;

	assign channelOk = (cmd.channel != '0) && (cmd.channel <= NumChannels);
	assign cueOk = (cmd.cue < NumCues);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int ch = 1; ch <= NumChannels; ch++)
			begin
				live[ch] <= '0;
			end
			for (int c = 0; c < NumCues; c++)
			begin
				for (int ch = 1; ch <= NumChannels; ch++)
				begin
					cueMem[c][ch] <= '0;
				end
			end
			cueValid <= '0;
		end
		else
		begin
			if (cmd.writeLevel && channelOk)
				live[cmd.channel] <= cmd.level;
			if (cmd.recordCue && cueOk)
			begin
				cueMem[cmd.cue] <= live; // Snapshot of the whole scene
				cueValid[cmd.cue] <= 1'b1;
			end
			if (cmd.recallCue && cueOk)
				live <= cueMem[cmd.cue];
		end
	end

	// Slot 0 is the start code, always zero
	always_comb
	begin
		if (slotIndex != '0 && slotIndex <= NumChannels)
			slotLevel = live[slotIndex];
		else
			slotLevel = '0;
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the lightBoard testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module lightBoardTb -o lightBoardSim &&
	./obj_dir/lightBoardSim | tee /dev/stderr | grep -q "TEST PASSED" &&
	echo "Simulation run passed" ||
	{ echo "Simulation run failed"; exit 1; }
